// File: cmac_link_params.svh
`ifndef CMAC_LINK_PARAMS_SVH
`define CMAC_LINK_PARAMS_SVH

`define CMAC_CNT_W 32                 // byte and packet totals
`define CMAC_ERR_W 16                 // error event counters
`define CMAC_WB_AW 4                  // word address, 16 registers
`define CMAC_WB_DW 32

// register map, word addresses
`define CMAC_REG_RX_GOOD_PKTS   4'd0
`define CMAC_REG_RX_TOTAL_PKTS  4'd1
`define CMAC_REG_RX_GOOD_BYTES  4'd2
`define CMAC_REG_RX_TOTAL_BYTES 4'd3
`define CMAC_REG_TX_GOOD_PKTS   4'd4
`define CMAC_REG_TX_TOTAL_PKTS  4'd5
`define CMAC_REG_TX_GOOD_BYTES  4'd6
`define CMAC_REG_TX_TOTAL_BYTES 4'd7
`define CMAC_REG_ALIGN_ERR      4'd8
`define CMAC_REG_CODE_ERR       4'd9
`define CMAC_REG_FCS_ERR        4'd10
`define CMAC_REG_PREAMBLE_ERR   4'd11
`define CMAC_REG_SFD_ERR        4'd12
`define CMAC_REG_OVF_CNT        4'd13
`define CMAC_REG_UNF_CNT        4'd14
`define CMAC_REG_STATUS         4'd15 // bit 0 rx up, bit 1 tx up

`endif

// File: cmac_link_pkg.sv
`include "cmac_link_params.svh"

package cmac_link_pkg;

  typedef logic [2:0]  seg_err_t;     // one flag per lbus segment
  typedef logic [6:0]  rx_bytes_t;    // rx bytes per cycle
  typedef logic [5:0]  tx_bytes_t;    // tx bytes per cycle
  typedef logic [13:0] good_bytes_t;  // good bytes per cycle

  typedef logic [`CMAC_CNT_W-1:0] cnt_t;
  typedef logic [`CMAC_ERR_W-1:0] err_cnt_t;
  typedef logic [`CMAC_WB_AW-1:0] wb_adr_t;
  typedef logic [`CMAC_WB_DW-1:0] wb_data_t;

  // rx bring-up
  typedef enum logic [1:0] {
    rx_idle,
    rx_gt_locked,                     // enable goes out here
    rx_wait_aligned,
    rx_link_up
  } rx_state_t;

  // tx bring-up, fault indication until aligned
  typedef enum logic [1:0] {
    tx_idle,
    tx_gt_locked,                     // lfi/rfi start here
    tx_wait_aligned,
    tx_link_up
  } tx_state_t;

endpackage

// File: cmac_link_if.sv
`timescale 1ns/1ps

// registered mac status and statistics
interface stat_if;
  import cmac_link_pkg::*;

  logic        aligned;
  logic        aligned_err;
  seg_err_t    bad_code;
  seg_err_t    bad_fcs;
  logic        bad_preamble;
  logic        bad_sfd;
  logic        ovf;                   // tx fifo overflow
  logic        unf;                   // tx fifo underflow
  rx_bytes_t   rx_total_bytes;
  good_bytes_t rx_good_bytes;
  logic        rx_good_pkts;
  seg_err_t    rx_total_pkts;         // up to 3 per cycle
  tx_bytes_t   tx_total_bytes;
  good_bytes_t tx_good_bytes;
  logic        tx_good_pkts;
  logic        tx_total_pkts;

  modport src (
    output aligned, aligned_err, bad_code, bad_fcs, bad_preamble, bad_sfd, ovf, unf,
    output rx_total_bytes, rx_good_bytes, rx_good_pkts, rx_total_pkts,
    output tx_total_bytes, tx_good_bytes, tx_good_pkts, tx_total_pkts
  );
  modport dst (
    input aligned, aligned_err, bad_code, bad_fcs, bad_preamble, bad_sfd, ovf, unf,
    input rx_total_bytes, rx_good_bytes, rx_good_pkts, rx_total_pkts,
    input tx_total_bytes, tx_good_bytes, tx_good_pkts, tx_total_pkts
  );
endinterface

// accumulated counters towards the register file
interface cnt_if;
  import cmac_link_pkg::*;

  cnt_t     rx_good_pkts, rx_total_pkts, rx_good_bytes, rx_total_bytes;
  cnt_t     tx_good_pkts, tx_total_pkts, tx_good_bytes, tx_total_bytes;
  err_cnt_t align_err, code_err, fcs_err, preamble_err, sfd_err, ovf_cnt, unf_cnt;

  modport src (
    output rx_good_pkts, rx_total_pkts, rx_good_bytes, rx_total_bytes,
    output tx_good_pkts, tx_total_pkts, tx_good_bytes, tx_total_bytes,
    output align_err, code_err, fcs_err, preamble_err, sfd_err, ovf_cnt, unf_cnt
  );
  modport dst (
    input rx_good_pkts, rx_total_pkts, rx_good_bytes, rx_total_bytes,
    input tx_good_pkts, tx_total_pkts, tx_good_bytes, tx_total_bytes,
    input align_err, code_err, fcs_err, preamble_err, sfd_err, ovf_cnt, unf_cnt
  );
endinterface

// File: stat_sampler.sv
`timescale 1ns/1ps

module stat_sampler (
  input  logic                       cmac_drp,
  input  logic                       usr_rx_reset_w,
  input  logic                       stat_rx_aligned,
  input  logic                       stat_rx_aligned_err,
  input  cmac_link_pkg::seg_err_t    stat_rx_bad_code,
  input  cmac_link_pkg::seg_err_t    stat_rx_bad_fcs,
  input  logic                       stat_rx_bad_preamble,
  input  logic                       stat_rx_bad_sfd,
  input  logic                       tx_ovfout,
  input  logic                       tx_unfout,
  input  cmac_link_pkg::rx_bytes_t   stat_rx_total_bytes,
  input  cmac_link_pkg::good_bytes_t stat_rx_total_good_bytes,
  input  logic                       stat_rx_total_good_packets,
  input  cmac_link_pkg::seg_err_t    stat_rx_total_packets,
  input  cmac_link_pkg::tx_bytes_t   stat_tx_total_bytes,
  input  cmac_link_pkg::good_bytes_t stat_tx_total_good_bytes,
  input  logic                       stat_tx_total_good_packets,
  input  logic                       stat_tx_total_packets,
  stat_if.src                        st
);

  // one register stage on every mac status bit, gives the fsms aligned_1d
  always_ff @(posedge cmac_drp) begin
    if (usr_rx_reset_w) begin
      st.aligned        <= 1'b0;            // no link during reset
      st.aligned_err    <= 1'b0;
      st.bad_code       <= '0;
      st.bad_fcs        <= '0;
      st.bad_preamble   <= 1'b0;
      st.bad_sfd        <= 1'b0;
      st.ovf            <= 1'b0;
      st.unf            <= 1'b0;
      st.rx_total_bytes <= '0;              // no stray counts at release
      st.rx_good_bytes  <= '0;
      st.rx_good_pkts   <= 1'b0;
      st.rx_total_pkts  <= '0;
      st.tx_total_bytes <= '0;
      st.tx_good_bytes  <= '0;
      st.tx_good_pkts   <= 1'b0;
      st.tx_total_pkts  <= 1'b0;
    end else begin
      st.aligned        <= stat_rx_aligned;
      st.aligned_err    <= stat_rx_aligned_err;
      st.bad_code       <= stat_rx_bad_code;
      st.bad_fcs        <= stat_rx_bad_fcs;
      st.bad_preamble   <= stat_rx_bad_preamble;
      st.bad_sfd        <= stat_rx_bad_sfd;
      st.ovf            <= tx_ovfout;
      st.unf            <= tx_unfout;
      st.rx_total_bytes <= stat_rx_total_bytes;
      st.rx_good_bytes  <= stat_rx_total_good_bytes;
      st.rx_good_pkts   <= stat_rx_total_good_packets;
      st.rx_total_pkts  <= stat_rx_total_packets;
      st.tx_total_bytes <= stat_tx_total_bytes;
      st.tx_good_bytes  <= stat_tx_total_good_bytes;
      st.tx_good_pkts   <= stat_tx_total_good_packets;
      st.tx_total_pkts  <= stat_tx_total_packets;
    end
  end

endmodule

// File: rx_bringup_fsm.sv
`timescale 1ns/1ps

module rx_bringup_fsm (
  input  logic cmac_drp,
  input  logic usr_rx_reset_w,
  stat_if.dst  st,
  output logic ctl_rx_enable,
  output logic rx_link_up
);
  import cmac_link_pkg::*;

  rx_state_t state;
  logic      reset_done;                    // high from 1st edge after reset

  always_ff @(posedge cmac_drp) begin
    if (usr_rx_reset_w) begin
      state         <= rx_idle;
      reset_done    <= 1'b0;
      ctl_rx_enable <= 1'b0;
    end else begin
      reset_done <= 1'b1;
      case (state)
        rx_idle: begin
          ctl_rx_enable <= 1'b0;            // drops here after align loss
          if (reset_done) state <= rx_gt_locked;
        end
        rx_gt_locked: begin
          ctl_rx_enable <= 1'b1;            // 3rd edge after reset release
          state         <= rx_wait_aligned;
        end
        rx_wait_aligned: begin
          if (st.aligned) state <= cmac_link_pkg::rx_link_up;
        end
        cmac_link_pkg::rx_link_up: begin
          if (!st.aligned) state <= rx_idle; // restart whole sequence
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // port name hides the enum literal, hence the scoped name
  assign rx_link_up = (state == cmac_link_pkg::rx_link_up);

endmodule

// File: tx_bringup_fsm.sv
`timescale 1ns/1ps

module tx_bringup_fsm (
  input  logic cmac_drp,
  input  logic usr_rx_reset_w,
  stat_if.dst  st,
  output logic ctl_tx_enable,
  output logic ctl_tx_send_lfi,
  output logic ctl_tx_send_rfi,
  output logic tx_link_up
);
  import cmac_link_pkg::*;

  tx_state_t state;
  logic      reset_done;                    // own flag, same timing as rx

  always_ff @(posedge cmac_drp) begin
    if (usr_rx_reset_w) begin
      state           <= tx_idle;
      reset_done      <= 1'b0;
      ctl_tx_enable   <= 1'b0;
      ctl_tx_send_lfi <= 1'b0;
      ctl_tx_send_rfi <= 1'b0;
    end else begin
      reset_done <= 1'b1;
      case (state)
        tx_idle: begin
          ctl_tx_enable   <= 1'b0;          // all quiet
          ctl_tx_send_lfi <= 1'b0;
          ctl_tx_send_rfi <= 1'b0;
          if (reset_done) state <= tx_gt_locked;
        end
        tx_gt_locked: begin
          ctl_tx_enable   <= 1'b0;
          ctl_tx_send_lfi <= 1'b1;          // tell far end we are not up
          ctl_tx_send_rfi <= 1'b1;
          state           <= tx_wait_aligned;
        end
        tx_wait_aligned: begin
          if (st.aligned) state <= cmac_link_pkg::tx_link_up;
        end
        cmac_link_pkg::tx_link_up: begin
          ctl_tx_send_lfi <= 1'b0;          // faults off, same edge as enable
          ctl_tx_send_rfi <= 1'b0;
          ctl_tx_enable   <= 1'b1;
          if (!st.aligned) state <= tx_idle;
        end
        default: state <= tx_idle;
      endcase
    end
  end

  assign tx_link_up = (state == cmac_link_pkg::tx_link_up);

endmodule

// File: stat_counters.sv
`timescale 1ns/1ps

module stat_counters (
  input  logic cmac_drp,
  input  logic usr_rx_reset_w,
  stat_if.dst  st,
  cnt_if.src   cnt
);
  import cmac_link_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // totals, add per-cycle increment, wrap at 2^32
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cmac_drp) begin
    if (usr_rx_reset_w) begin
      cnt.rx_good_pkts   <= '0;
      cnt.rx_total_pkts  <= '0;
      cnt.rx_good_bytes  <= '0;
      cnt.rx_total_bytes <= '0;
      cnt.tx_good_pkts   <= '0;
      cnt.tx_total_pkts  <= '0;
      cnt.tx_good_bytes  <= '0;
      cnt.tx_total_bytes <= '0;
    end else begin
      cnt.rx_good_pkts   <= cnt.rx_good_pkts + cnt_t'(st.rx_good_pkts);
      cnt.rx_total_pkts  <= cnt.rx_total_pkts + cnt_t'(st.rx_total_pkts); // 0..3
      cnt.rx_good_bytes  <= cnt.rx_good_bytes + cnt_t'(st.rx_good_bytes);
      cnt.rx_total_bytes <= cnt.rx_total_bytes + cnt_t'(st.rx_total_bytes);
      cnt.tx_good_pkts   <= cnt.tx_good_pkts + cnt_t'(st.tx_good_pkts);
      cnt.tx_total_pkts  <= cnt.tx_total_pkts + cnt_t'(st.tx_total_pkts);
      cnt.tx_good_bytes  <= cnt.tx_good_bytes + cnt_t'(st.tx_good_bytes);
      cnt.tx_total_bytes <= cnt.tx_total_bytes + cnt_t'(st.tx_total_bytes);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // error events, one count per cycle with any flag set
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cmac_drp) begin
    if (usr_rx_reset_w) begin
      cnt.align_err    <= '0;
      cnt.code_err     <= '0;
      cnt.fcs_err      <= '0;
      cnt.preamble_err <= '0;
      cnt.sfd_err      <= '0;
      cnt.ovf_cnt      <= '0;
      cnt.unf_cnt      <= '0;
    end else begin
      if (st.aligned_err) cnt.align_err <= cnt.align_err + 1'b1;
      if (|st.bad_code) cnt.code_err <= cnt.code_err + 1'b1;  // any segment
      if (|st.bad_fcs) cnt.fcs_err <= cnt.fcs_err + 1'b1;
      if (st.bad_preamble) cnt.preamble_err <= cnt.preamble_err + 1'b1;
      if (st.bad_sfd) cnt.sfd_err <= cnt.sfd_err + 1'b1;
      if (st.ovf) cnt.ovf_cnt <= cnt.ovf_cnt + 1'b1;         // tx fifo
      if (st.unf) cnt.unf_cnt <= cnt.unf_cnt + 1'b1;
    end
  end

endmodule

// File: wb_stat_regs.sv
`timescale 1ns/1ps
`include "cmac_link_params.svh"

module wb_stat_regs (
  input  logic                    cmac_drp,
  input  logic                    usr_rx_reset_w,
  cnt_if.dst                      cnt,
  input  logic                    rx_link_up,
  input  logic                    tx_link_up,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  cmac_link_pkg::wb_adr_t  wb_adr,
  input  cmac_link_pkg::wb_data_t wb_wdata,  // read-only map, data dropped
  output cmac_link_pkg::wb_data_t wb_rdata,
  output logic                    wb_ack
);
  import cmac_link_pkg::*;

  wb_data_t rd_mux;
  logic     req;                         // new access this cycle

  assign req = wb_cyc & wb_stb & ~wb_ack; // ack cycle never starts another

  ////////////////////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (wb_adr)
      `CMAC_REG_RX_GOOD_PKTS:   rd_mux = cnt.rx_good_pkts;
      `CMAC_REG_RX_TOTAL_PKTS:  rd_mux = cnt.rx_total_pkts;
      `CMAC_REG_RX_GOOD_BYTES:  rd_mux = cnt.rx_good_bytes;
      `CMAC_REG_RX_TOTAL_BYTES: rd_mux = cnt.rx_total_bytes;
      `CMAC_REG_TX_GOOD_PKTS:   rd_mux = cnt.tx_good_pkts;
      `CMAC_REG_TX_TOTAL_PKTS:  rd_mux = cnt.tx_total_pkts;
      `CMAC_REG_TX_GOOD_BYTES:  rd_mux = cnt.tx_good_bytes;
      `CMAC_REG_TX_TOTAL_BYTES: rd_mux = cnt.tx_total_bytes;
      `CMAC_REG_ALIGN_ERR:      rd_mux = wb_data_t'(cnt.align_err);  // zero ext
      `CMAC_REG_CODE_ERR:       rd_mux = wb_data_t'(cnt.code_err);
      `CMAC_REG_FCS_ERR:        rd_mux = wb_data_t'(cnt.fcs_err);
      `CMAC_REG_PREAMBLE_ERR:   rd_mux = wb_data_t'(cnt.preamble_err);
      `CMAC_REG_SFD_ERR:        rd_mux = wb_data_t'(cnt.sfd_err);
      `CMAC_REG_OVF_CNT:        rd_mux = wb_data_t'(cnt.ovf_cnt);
      `CMAC_REG_UNF_CNT:        rd_mux = wb_data_t'(cnt.unf_cnt);
      `CMAC_REG_STATUS:         rd_mux = wb_data_t'({tx_link_up, rx_link_up});
      default:                  rd_mux = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // one-cycle ack, rdata registered with it
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cmac_drp) begin
    if (usr_rx_reset_w) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;                      // single pulse, low the cycle after
    end
  end

  always_ff @(posedge cmac_drp) begin
    if (req) begin
      wb_rdata <= wb_we ? '0 : rd_mux;    // writes acked, no effect
    end
  end

endmodule

// File: cmac_link_ctrl.sv
`timescale 1ns/1ps

module cmac_link_ctrl (
  input  logic                       cmac_drp,
  input  logic                       usr_rx_reset_w,
  // mac status and statistics
  input  logic                       stat_rx_aligned,
  input  logic                       stat_rx_aligned_err,
  input  cmac_link_pkg::seg_err_t    stat_rx_bad_code,
  input  cmac_link_pkg::seg_err_t    stat_rx_bad_fcs,
  input  logic                       stat_rx_bad_preamble,
  input  logic                       stat_rx_bad_sfd,
  input  logic                       tx_ovfout,
  input  logic                       tx_unfout,
  input  cmac_link_pkg::rx_bytes_t   stat_rx_total_bytes,
  input  cmac_link_pkg::good_bytes_t stat_rx_total_good_bytes,
  input  logic                       stat_rx_total_good_packets,
  input  cmac_link_pkg::seg_err_t    stat_rx_total_packets,
  input  cmac_link_pkg::tx_bytes_t   stat_tx_total_bytes,
  input  cmac_link_pkg::good_bytes_t stat_tx_total_good_bytes,
  input  logic                       stat_tx_total_good_packets,
  input  logic                       stat_tx_total_packets,
  // mac control
  output logic                       ctl_rx_enable,
  output logic                       ctl_tx_enable,
  output logic                       ctl_tx_send_lfi,
  output logic                       ctl_tx_send_rfi,
  output logic                       link_up,       // tx side up, link usable
  // wishbone classic slave
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  cmac_link_pkg::wb_adr_t     wb_adr,
  input  cmac_link_pkg::wb_data_t    wb_wdata,
  output cmac_link_pkg::wb_data_t    wb_rdata,
  output logic                       wb_ack
);

  stat_if st ();                              // sampled mac status
  cnt_if  cnt ();                             // counters to register file

  logic rx_link_up;
  logic tx_link_up;

  assign link_up = tx_link_up;

  stat_sampler i_stat_sampler (
    .cmac_drp, .usr_rx_reset_w,
    .stat_rx_aligned, .stat_rx_aligned_err, .stat_rx_bad_code, .stat_rx_bad_fcs,
    .stat_rx_bad_preamble, .stat_rx_bad_sfd, .tx_ovfout, .tx_unfout,
    .stat_rx_total_bytes, .stat_rx_total_good_bytes,
    .stat_rx_total_good_packets, .stat_rx_total_packets,
    .stat_tx_total_bytes, .stat_tx_total_good_bytes,
    .stat_tx_total_good_packets, .stat_tx_total_packets,
    .st (st)
  );

  rx_bringup_fsm i_rx_fsm (
    .cmac_drp, .usr_rx_reset_w,
    .st            (st),
    .ctl_rx_enable,
    .rx_link_up
  );

  tx_bringup_fsm i_tx_fsm (
    .cmac_drp, .usr_rx_reset_w,
    .st            (st),
    .ctl_tx_enable, .ctl_tx_send_lfi, .ctl_tx_send_rfi,
    .tx_link_up
  );

  stat_counters i_stat_counters (
    .cmac_drp, .usr_rx_reset_w,
    .st  (st),
    .cnt (cnt)
  );

  wb_stat_regs i_wb_stat_regs (
    .cmac_drp, .usr_rx_reset_w,
    .cnt (cnt),
    .rx_link_up, .tx_link_up,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack
  );

endmodule

// File: cmac_link_assertions.sv
`timescale 1ns/1ps

module cmac_link_assertions (
  input logic cmac_drp,
  input logic usr_rx_reset_w,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic ctl_rx_enable,
  input logic ctl_tx_enable,
  input logic ctl_tx_send_lfi
);

  // ack only answers a request seen the cycle before
  ack_follows_req: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without a preceding cyc and stb");

  ack_one_cycle: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
    wb_ack |=> !wb_ack)                            // single pulse
    else $error("wb_ack held longer than one cycle");

  tx_needs_rx: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
    ctl_tx_enable |-> ctl_rx_enable)
    else $error("tx enabled while rx disabled");

  no_lfi_when_up: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
    !(ctl_tx_send_lfi && ctl_tx_enable))           // faults off before enable
    else $error("lfi sent while tx enabled");

endmodule

bind cmac_link_ctrl cmac_link_assertions i_assertions (.*);

// File: tb_cmac_link_ctrl.sv
`timescale 1ns/1ps
`include "cmac_link_params.svh"

module tb_cmac_link_ctrl;
  import cmac_link_pkg::*;

  localparam int CLK_NS       = 100;
  localparam int RESET_CYC    = 10;
  localparam int BRINGUP_CYC  = 40;               // two bring-up passes, with margin
  localparam int RAND_CYC     = 2000;
  localparam int READ_CYC     = 64 * 4;           // accesses times worst-case length
  localparam int WATCHDOG_CYC = 2 * (RESET_CYC + BRINGUP_CYC + RAND_CYC + READ_CYC);
  localparam int ACK_WAIT     = 8;

  logic        cmac_drp;
  logic        usr_rx_reset_w;
  logic        stat_rx_aligned;
  logic        stat_rx_aligned_err;
  seg_err_t    stat_rx_bad_code;
  seg_err_t    stat_rx_bad_fcs;
  logic        stat_rx_bad_preamble;
  logic        stat_rx_bad_sfd;
  logic        tx_ovfout;
  logic        tx_unfout;
  rx_bytes_t   stat_rx_total_bytes;
  good_bytes_t stat_rx_total_good_bytes;
  logic        stat_rx_total_good_packets;
  seg_err_t    stat_rx_total_packets;
  tx_bytes_t   stat_tx_total_bytes;
  good_bytes_t stat_tx_total_good_bytes;
  logic        stat_tx_total_good_packets;
  logic        stat_tx_total_packets;
  logic        ctl_rx_enable;
  logic        ctl_tx_enable;
  logic        ctl_tx_send_lfi;
  logic        ctl_tx_send_rfi;
  logic        link_up;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  wb_adr_t     wb_adr;
  wb_data_t    wb_wdata;
  wb_data_t    wb_rdata;
  logic        wb_ack;

  cnt_t        model_tot [8];                     // indexed by register address
  err_cnt_t    model_err [7];                     // register address minus 8
  logic [1:0]  model_status;                      // {tx up, rx up}
  wb_data_t    rd;
  int          acks;

  cmac_link_ctrl i_dut (.*);

  initial begin
    cmac_drp = 1'b0;
    forever #(CLK_NS / 2) cmac_drp = ~cmac_drp;
  end

  ////////////////////////////////////////////////////////////////////////////
  // model and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic wb_data_t expected_reg(input wb_adr_t adr);
    wb_data_t val;
    if (adr < `CMAC_REG_ALIGN_ERR) val = model_tot[adr[2:0]];   // 32-bit totals
    else if (adr == `CMAC_REG_STATUS) val = wb_data_t'(model_status);
    else val = wb_data_t'(model_err[int'(adr) - 8]);           // zero extended
    return val;
  endfunction

  task automatic check(input string what, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic step();                          // next edge, then 1 ns
    @(posedge cmac_drp);
    #1;
  endtask

  task automatic clear_stats();
    stat_rx_aligned_err        = 1'b0;
    stat_rx_bad_code           = '0;
    stat_rx_bad_fcs            = '0;
    stat_rx_bad_preamble       = 1'b0;
    stat_rx_bad_sfd            = 1'b0;
    tx_ovfout                  = 1'b0;
    tx_unfout                  = 1'b0;
    stat_rx_total_bytes        = '0;
    stat_rx_total_good_bytes   = '0;
    stat_rx_total_good_packets = 1'b0;
    stat_rx_total_packets      = '0;
    stat_tx_total_bytes        = '0;
    stat_tx_total_good_bytes   = '0;
    stat_tx_total_good_packets = 1'b0;
    stat_tx_total_packets      = 1'b0;
  endtask

  task automatic drive_random();                  // one cycle of stimulus, model follows
    stat_rx_total_good_packets = 1'($urandom_range(0, 1));
    stat_rx_total_packets      = seg_err_t'($urandom_range(0, 3));
    stat_rx_total_good_bytes   = good_bytes_t'($urandom_range(0, 16383));
    stat_rx_total_bytes        = rx_bytes_t'($urandom_range(0, 127));
    stat_tx_total_good_packets = 1'($urandom_range(0, 1));
    stat_tx_total_packets      = 1'($urandom_range(0, 1));
    stat_tx_total_good_bytes   = good_bytes_t'($urandom_range(0, 16383));
    stat_tx_total_bytes        = tx_bytes_t'($urandom_range(0, 63));
    stat_rx_aligned_err  = ($urandom_range(0, 7) == 0);
    stat_rx_bad_code     = ($urandom_range(0, 3) == 0) ? seg_err_t'($urandom_range(1, 7)) : '0;
    stat_rx_bad_fcs      = ($urandom_range(0, 3) == 0) ? seg_err_t'($urandom_range(1, 7)) : '0;
    stat_rx_bad_preamble = ($urandom_range(0, 5) == 0);
    stat_rx_bad_sfd      = ($urandom_range(0, 5) == 0);
    tx_ovfout            = ($urandom_range(0, 9) == 0);   // rare fifo events
    tx_unfout            = ($urandom_range(0, 9) == 0);
    model_tot[0] += cnt_t'(stat_rx_total_good_packets);
    model_tot[1] += cnt_t'(stat_rx_total_packets);
    model_tot[2] += cnt_t'(stat_rx_total_good_bytes);
    model_tot[3] += cnt_t'(stat_rx_total_bytes);
    model_tot[4] += cnt_t'(stat_tx_total_good_packets);
    model_tot[5] += cnt_t'(stat_tx_total_packets);
    model_tot[6] += cnt_t'(stat_tx_total_good_bytes);
    model_tot[7] += cnt_t'(stat_tx_total_bytes);
    model_err[0] += err_cnt_t'(stat_rx_aligned_err);
    model_err[1] += err_cnt_t'(|stat_rx_bad_code);         // any segment counts once
    model_err[2] += err_cnt_t'(|stat_rx_bad_fcs);
    model_err[3] += err_cnt_t'(stat_rx_bad_preamble);
    model_err[4] += err_cnt_t'(stat_rx_bad_sfd);
    model_err[5] += err_cnt_t'(tx_ovfout);
    model_err[6] += err_cnt_t'(tx_unfout);
  endtask

  task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                           output wb_data_t rdata);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = wdata;
    do begin
      step();
      waited++;
      if (waited > ACK_WAIT) begin
        $display("no Wishbone ack within %0d cycles for address %0d", ACK_WAIT, adr);
        $display("Simulation failed");
        $fatal(1, "bus hang");
      end
    end while (!wb_ack);
    rdata  = wb_rdata;                            // valid with ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    step();
    check("ack one cycle after access", wb_data_t'(wb_ack), '0);
  endtask

  task automatic read_check(input wb_adr_t adr);
    wb_data_t val;
    wb_access(1'b0, adr, '0, val);
    check($sformatf("register %0d", adr), val, expected_reg(adr));
  endtask

  task automatic check_all_regs();
    for (int a = 0; a < 16; a++) read_check(wb_adr_t'(a));
  endtask

  task automatic check_outputs(input string what, input logic [4:0] exp);
    check(what, wb_data_t'({ctl_rx_enable, ctl_tx_enable, ctl_tx_send_lfi,
                            ctl_tx_send_rfi, link_up}), wb_data_t'(exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(76));
    usr_rx_reset_w = 1'b1;
    stat_rx_aligned = 1'b0;
    clear_stats();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdata = '0;
    model_status = 2'b00;
    foreach (model_tot[i]) model_tot[i] = '0;
    foreach (model_err[i]) model_err[i] = '0;
    repeat (RESET_CYC) step();
    check_outputs("outputs in reset", 5'b00000);       // rx_en tx_en lfi rfi up
    check("ack in reset", wb_data_t'(wb_ack), '0);
    usr_rx_reset_w = 1'b0;
    step();
    check_outputs("1 cycle after reset", 5'b00000);
    step();
    check_outputs("2 cycles after reset", 5'b00000);
    step();
    check_outputs("3 cycles after reset", 5'b10110);   // rx enable, faults out
    check_all_regs();                                  // all zero, status 0
    stat_rx_aligned = 1'b1;
    repeat (6) step();
    check_outputs("link up", 5'b11001);
    model_status = 2'b11;
    read_check(`CMAC_REG_STATUS);
    stat_rx_aligned = 1'b0;
    model_status = 2'b00;
    repeat (3) step();
    check_outputs("alignment lost", 5'b00000);
    step();
    check_outputs("bring-up restart", 5'b10110);
    read_check(`CMAC_REG_STATUS);
    repeat (RAND_CYC) begin
      drive_random();
      step();
    end
    clear_stats();
    repeat (4) step();                                 // end-to-end latency
    for (int a = 0; a < 15; a++) read_check(wb_adr_t'(a));
    wb_access(1'b1, `CMAC_REG_RX_GOOD_BYTES, 32'hffff_ffff, rd);
    check("rdata on write ack", rd, '0);
    wb_access(1'b1, `CMAC_REG_STATUS, 32'h0000_0003, rd);
    check("rdata on status write ack", rd, '0);
    check_all_regs();                                  // writes had no effect
    acks = 0;
    wb_cyc = 1'b1;                                     // strobe held for 4 cycles
    wb_stb = 1'b1;
    wb_adr = `CMAC_REG_TX_TOTAL_BYTES;
    repeat (4) begin
      step();
      if (wb_ack) acks++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    step();
    check("acks for held strobe", wb_data_t'(acks), 32'd2);
    check("ack after held strobe", wb_data_t'(wb_ack), '0);
    $display("Simulation passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_NS);
    $display("watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYC);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

// File: verilog.f
+incdir+.
cmac_link_pkg.sv
cmac_link_if.sv
stat_sampler.sv
rx_bringup_fsm.sv
tx_bringup_fsm.sv
stat_counters.sv
wb_stat_regs.sv
cmac_link_ctrl.sv
cmac_link_assertions.sv
tb_cmac_link_ctrl.sv

// File: Bender.yml
package:
  name: cmac_link_ctrl

sources:
  - include_dirs:
      - .
    files:
      - cmac_link_pkg.sv
      - cmac_link_if.sv
      - stat_sampler.sv
      - rx_bringup_fsm.sv
      - tx_bringup_fsm.sv
      - stat_counters.sv
      - wb_stat_regs.sv
      - cmac_link_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - cmac_link_assertions.sv
      - tb_cmac_link_ctrl.sv
